// ==== Makefile ====
TOP := decoderTb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -j 0 --top-module $(TOP) -f all.f --Mdir obj_dir

run: build
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "TB PASSED" sim.log

lint:
	verilator --lint-only --timing --top-module $(TOP) -f all.f

clean:
	rm -rf obj_dir sim.log

// ==== all.f ====
+incdir+src
src/decoderPkg.sv
src/condFlags.sv
src/execDecode.sv
src/flowDecode.sv
src/decoderWithCc.sv
verification/decoderTb.sv

// ==== src/condFlags.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "decoder_defs.svh"

module condFlags import decoderPkg::*; (
    input  wire              clk,
    input  wire              rstN,
    input  wire              testFlag,      // Asynchronous TEST pin
    input  wire [`DATA_W-1:0] opa,
    input  wire flagUpdT     flagUpd,
    input  wire              carryFromAlu,
    input  wire              zeroFromAlu,
    output logic             carryFlag,
    output logic             zeroFlag,
    output logic             ccOut
);

    logic testMeta;
    logic testSync;
    logic condRaw;

    // Two-stage synchronizer for the TEST pin
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            testMeta <= 1'b0;
            testSync <= 1'b0;
        end else begin
            testMeta <= testFlag;
            testSync <= testMeta;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            carryFlag <= 1'b0;
            zeroFlag  <= 1'b0;
        end else begin
            case (flagUpd.carryAct)
                carryAlu:    carryFlag <= carryFromAlu;
                carryClear:  carryFlag <= 1'b0;
                carrySet:    carryFlag <= 1'b1;
                carryInvert: carryFlag <= ~carryFlag;   // CMC
                default:     carryFlag <= carryFlag;
            endcase
            if (flagUpd.zeroLoad) begin
                zeroFlag <= zeroFromAlu;
            end
        end
    end

    // JCN condition, opa = {invert, zero, carry, notTest}
    assign condRaw = (~testSync & opa[0]) | (carryFlag & opa[1]) | (zeroFlag & opa[2]);
    assign ccOut   = condRaw ^ opa[3];

endmodule

`default_nettype wire

// ==== src/decoderPkg.sv ====
`default_nettype none

`include "decoder_defs.svh"

package decoderPkg;

    // Major opcodes (upper ROM nibble)
    typedef enum logic [`DATA_W-1:0] {
        NOP, JCN, FIM, FIN,    // FIM/SRC and FIN/JIN split on opa[0]
        JUN, JMS, INC, ISZ,
        ADD, SUB, LD,  XCH,
        BBL, LDM, grpE, grpF   // grpE is I/O and RAM, not decoded here
    } oprE;

    // Accumulator group subcodes, opr = grpF
    typedef enum logic [`DATA_W-1:0] {
        CLB, CLC, IAC, CMC,
        CMA, RAL, RAR, TCC,
        DAC, TCS, STC, DAA,
        KBP, DCL
    } fOpE;

    typedef enum logic [`CYCLE_W-1:0] {
        cycA1, cycA2, cycA3, cycM1, cycM2, cycX1, cycX2, cycX3
    } microCycleE;

    // ALU operand source, code 2 unused
    typedef enum logic [1:0] {
        srcReg  = 2'd0,
        srcImm  = 2'd1,
        srcNone = 2'd3
    } aluSrcE;

    typedef enum logic [2:0] {
        carryKeep, carryAlu, carryClear, carrySet, carryInvert
    } carryActE;

    // ---------------------------------------------------------------------------
    // Control bundles
    // ---------------------------------------------------------------------------

    typedef struct packed {
        carryActE carryAct;
        logic     zeroLoad;       // Zero flag takes zeroFromAlu
    } flagUpdT;

    typedef struct packed {
        logic   enable;
        oprE    op;
        fOpE    subOp;
        aluSrcE src;
    } aluCtrlT;

    typedef struct packed {
        logic accWe;
        logic tempWe;
        logic regWe;
        logic regSrcSel;          // Register write-back from temp (XCH)
    } regCtrlT;

    typedef struct packed {
        logic                pcLoad;
        logic [`ADDR_W-1:0]  pcLoadData;
        logic                stackPush;
        logic                stackPop;
        logic                pcLoadUsePair;
    } pcCtrlT;

    typedef struct packed {
        logic                   pairWe;
        logic [`PAIR_SEL_W-1:0] pairAddr;
        logic [`PAIR_W-1:0]     pairDin;
    } pairCtrlT;

endpackage

`default_nettype wire

// ==== src/decoderWithCc.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "decoder_defs.svh"

module decoderWithCc import decoderPkg::*; (
    input  wire               clk,
    input  wire               rstN,
    input  wire oprE          opr,
    input  wire [`DATA_W-1:0] opa,
    input  wire microCycleE   cycle,          // From the microcycle generator
    input  wire               carryFromAlu,
    input  wire               zeroFromAlu,
    input  wire               testFlag,
    input  wire               immFetchActive,
    input  wire [`ADDR_W-1:0] immAddr,
    output aluCtrlT           aluCtrl,
    output regCtrlT           regCtrl,
    output pcCtrlT            pcCtrl,
    output pairCtrlT          pairCtrl,
    output logic              needImm,
    output logic              finImm,
    output logic              carryFlag,
    output logic              zeroFlag,
    output logic              ccOut
);

    flagUpdT flagUpd;   // Flag action for the current microcycle

    execDecode uExecDecode (
        .clk            (clk),
        .rstN           (rstN),
        .opr            (opr),
        .opa            (opa),
        .cycle          (cycle),
        .immFetchActive (immFetchActive),
        .aluCtrl        (aluCtrl),
        .regCtrl        (regCtrl),
        .flagUpd        (flagUpd)
    );

    condFlags uCondFlags (
        .clk          (clk),
        .rstN         (rstN),
        .testFlag     (testFlag),
        .opa          (opa),
        .flagUpd      (flagUpd),
        .carryFromAlu (carryFromAlu),
        .zeroFromAlu  (zeroFromAlu),
        .carryFlag    (carryFlag),
        .zeroFlag     (zeroFlag),
        .ccOut        (ccOut)
    );

    flowDecode uFlowDecode (
        .clk            (clk),
        .rstN           (rstN),
        .opr            (opr),
        .opa            (opa),
        .cycle          (cycle),
        .immFetchActive (immFetchActive),
        .immAddr        (immAddr),
        .zeroFromAlu    (zeroFromAlu),
        .ccOut          (ccOut),
        .pcCtrl         (pcCtrl),
        .pairCtrl       (pairCtrl),
        .needImm        (needImm),
        .finImm         (finImm)
    );

endmodule

`default_nettype wire

// ==== src/decoder_defs.svh ====
`ifndef DECODER_DEFS_SVH
`define DECODER_DEFS_SVH

// ---------------------------------------------------------------------------
// Datapath widths for the instruction decoder
// ---------------------------------------------------------------------------

// Nibble (opr / opa / accumulator)
`define DATA_W      4
// ROM address
`define ADDR_W      12
// Register pair contents
`define PAIR_W      8
// Microcycle index A1..X3
`define CYCLE_W     3
// Register index into the file of 16 nibbles
`define PAIR_SEL_W  4

`endif

// ==== src/execDecode.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "decoder_defs.svh"

module execDecode import decoderPkg::*; (
    input  wire               clk,
    input  wire               rstN,
    input  wire oprE          opr,
    input  wire [`DATA_W-1:0] opa,
    input  wire microCycleE   cycle,
    input  wire               immFetchActive,  // Second word of a two-word instruction
    output aluCtrlT           aluCtrl,
    output regCtrlT           regCtrl,
    output flagUpdT           flagUpd
);

    fOpE     fOp;
    logic    isX3;
    aluCtrlT aluNext;
    regCtrlT regNext;

    assign fOp  = fOpE'(opa);
    assign isX3 = (cycle == cycX3);

    // ---------------------------------------------------------------------------
    // ALU and register-file strobes
    // ---------------------------------------------------------------------------

    always_comb begin
        aluNext = '{enable: 1'b0, op: NOP, subOp: CLB, src: srcNone};
        regNext = '0;
        regNext.tempWe = (cycle == cycX1);   // Temp <- ACC in every frame

        case (opr)
            INC: begin
                aluNext = '{enable: 1'b1, op: INC, subOp: CLB, src: srcReg};
                regNext.regWe = isX3;
            end

            ISZ: begin
                if (immFetchActive) begin
                    // Increment once at X2, write back at X3
                    if (cycle == cycX2) begin
                        aluNext = '{enable: 1'b1, op: INC, subOp: CLB, src: srcReg};
                    end
                    regNext.regWe = isX3;
                end
            end

            ADD, SUB, LD: begin
                aluNext = '{enable: 1'b1, op: opr, subOp: CLB, src: srcReg};
                regNext.accWe = isX3;
            end

            XCH: begin
                // Reg passes to ACC via LD, old ACC comes back from temp
                aluNext = '{enable: 1'b1, op: LD, subOp: CLB, src: srcReg};
                regNext.accWe     = isX3;
                regNext.regWe     = isX3;
                regNext.regSrcSel = isX3;
            end

            BBL, LDM: begin
                aluNext = '{enable: 1'b1, op: opr, subOp: CLB, src: srcImm};
                regNext.accWe = isX3;
            end

            grpF: begin
                if (opa < 4'hD) begin              // DCL and reserved codes are no-ops
                    aluNext = '{enable: 1'b1, op: grpF, subOp: fOp, src: srcNone};
                    case (fOp)
                        CLC, CMC, STC: regNext.accWe = 1'b0;   // Carry only
                        default:       regNext.accWe = isX3;
                    endcase
                end
            end

            default: ;
        endcase
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            aluCtrl <= '{enable: 1'b0, op: NOP, subOp: CLB, src: srcReg};
            regCtrl <= '0;
        end else begin
            aluCtrl <= aluNext;
            regCtrl <= regNext;
        end
    end

    // ---------------------------------------------------------------------------
    // Flag actions, applied by condFlags at the X3 edge
    // ---------------------------------------------------------------------------

    always_comb begin
        flagUpd = '{carryAct: carryKeep, zeroLoad: 1'b0};
        if (isX3) begin
            case (opr)
                INC, ADD, SUB: flagUpd = '{carryAct: carryAlu, zeroLoad: 1'b1};
                LD, LDM, XCH:  flagUpd.zeroLoad = 1'b1;
                grpF: begin
                    case (fOp)
                        CLB, TCC:      flagUpd = '{carryAct: carryClear, zeroLoad: 1'b1};
                        CLC, TCS:      flagUpd.carryAct = carryClear;
                        STC:           flagUpd.carryAct = carrySet;
                        CMC:           flagUpd.carryAct = carryInvert;
                        IAC, DAC, DAA: flagUpd = '{carryAct: carryAlu, zeroLoad: 1'b1};
                        RAL, RAR:      flagUpd.carryAct = carryAlu;   // Rotate through carry
                        CMA, KBP:      flagUpd.zeroLoad = 1'b1;
                        default: ;
                    endcase
                end
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== src/flowDecode.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "decoder_defs.svh"

module flowDecode import decoderPkg::*; (
    input  wire               clk,
    input  wire               rstN,
    input  wire oprE          opr,
    input  wire [`DATA_W-1:0] opa,
    input  wire microCycleE   cycle,
    input  wire               immFetchActive,
    input  wire [`ADDR_W-1:0] immAddr,         // Target assembled outside from A2A1
    input  wire               zeroFromAlu,
    input  wire               ccOut,
    output pcCtrlT            pcCtrl,
    output pairCtrlT          pairCtrl,
    output logic              needImm,
    output logic              finImm
);

    logic                   isX3;
    logic                   firstX3;       // X3 of the first word
    logic                   secondX3;      // X3 of the second word
    logic [`PAIR_SEL_W-1:0] evenPair;
    logic                   zeroAtX2;      // ISZ result zero, held into X3
    pcCtrlT                 pcNext;
    pairCtrlT               pairNext;
    logic                   needNext;
    logic                   finNext;

    assign isX3     = (cycle == cycX3);
    assign firstX3  = isX3 && !immFetchActive;
    assign secondX3 = isX3 && immFetchActive;
    assign evenPair = {opa[`DATA_W-1:1], 1'b0};

    // ---------------------------------------------------------------------------
    // Next-state decode for PC, stack and pair strobes
    // ---------------------------------------------------------------------------

    always_comb begin
        pcNext   = '0;
        pairNext = '0;
        needNext = 1'b0;
        finNext  = 1'b0;

        case (opr)
            JCN: begin
                needNext = firstX3;
                if (secondX3 && ccOut) begin
                    pcNext.pcLoad     = 1'b1;
                    pcNext.pcLoadData = immAddr;
                end
            end

            FIM, FIN: begin
                if (!opa[0]) begin
                    needNext = firstX3;
                    finNext  = firstX3 && (opr == FIN);  // Fetch from pair 0 index
                    if (secondX3) begin
                        pairNext.pairWe   = 1'b1;
                        pairNext.pairAddr = evenPair;
                        pairNext.pairDin  = immAddr[`PAIR_W-1:0];
                    end
                end else begin
                    // SRC / JIN select the pair at X1
                    if (cycle == cycX1) begin
                        pairNext.pairAddr = evenPair;
                    end
                    pcNext.pcLoadUsePair = isX3 && (opr == FIN);
                end
            end

            JUN, JMS: begin
                needNext = firstX3;
                if (secondX3) begin
                    pcNext.pcLoad     = 1'b1;
                    pcNext.pcLoadData = immAddr;
                    pcNext.stackPush  = (opr == JMS);
                end
            end

            ISZ: begin
                needNext = firstX3;
                if (secondX3 && !zeroAtX2) begin    // Loop back while nonzero
                    pcNext.pcLoad     = 1'b1;
                    pcNext.pcLoadData = immAddr;
                end
            end

            BBL: pcNext.stackPop = isX3;

            default: ;
        endcase
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pcCtrl   <= '0;
            pairCtrl <= '0;
            needImm  <= 1'b0;
            finImm   <= 1'b0;
            zeroAtX2 <= 1'b0;
        end else begin
            pcCtrl   <= pcNext;
            pairCtrl <= pairNext;
            needImm  <= needNext;
            finImm   <= finNext;
            if (opr == ISZ && immFetchActive && cycle == cycX2) begin
                zeroAtX2 <= zeroFromAlu;
            end else begin
                zeroAtX2 <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== verification/decoderTb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "decoder_defs.svh"

module decoderTb import decoderPkg::*; ();

    // Table row of DUT inputs and the outputs expected after the next edge
    typedef struct packed {
        oprE                opr;
        logic [`DATA_W-1:0] opa;
        microCycleE         cycle;
        logic               immFetch;
        logic [`ADDR_W-1:0] immAddr;
        logic               carryIn;
        logic               zeroIn;
        logic               testIn;
        aluCtrlT            expAlu;
        regCtrlT            expReg;
        pcCtrlT             expPc;
        pairCtrlT           expPair;
        logic               expNeed;
        logic               expFin;
        logic               expCarry;
        logic               expZero;
        logic               expCc;
    } rowT;

    localparam aluCtrlT aluIdle  = '{enable: 1'b0, op: NOP, subOp: CLB, src: srcNone};
    localparam regCtrlT regIdle  = 4'b0000;
    localparam regCtrlT accOnly  = 4'b1000;
    localparam regCtrlT tempOnly = 4'b0100;
    localparam regCtrlT regOnly  = 4'b0010;
    localparam regCtrlT xchWb    = 4'b1011;   // ACC, reg and temp write-back

    logic               clk;
    logic               rstN;
    oprE                opr;
    logic [`DATA_W-1:0] opa;
    microCycleE         cycle;
    logic               carryFromAlu;
    logic               zeroFromAlu;
    logic               testFlag;
    logic               immFetchActive;
    logic [`ADDR_W-1:0] immAddr;
    aluCtrlT            aluCtrl;
    regCtrlT            regCtrl;
    pcCtrlT             pcCtrl;
    pairCtrlT           pairCtrl;
    logic               needImm;
    logic               finImm;
    logic               carryFlag;
    logic               zeroFlag;
    logic               ccOut;

    rowT         rows[$];
    logic [31:0] lcgState;
    logic        modelCarry;     // Predicted carry flag
    logic        modelZero;
    logic        testLevel;      // TEST level for rows being built
    logic        lastTest;       // TEST level of the previous row
    int          curRow;

    decoderWithCc u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        rstN = 1'b0;
        repeat (3) @(posedge clk);
        #1 rstN = 1'b1;
    end

    initial begin
        #2000;
        $display("Timeout: the table did not finish within the time limit");
        $display("TB FAILED");
        $fatal(1, "Watchdog expired");
    end

    // ---------------------------------------------------------------------------
    // Reference helpers
    // ---------------------------------------------------------------------------

    function automatic logic [31:0] nextRand();
        lcgState = lcgState * 32'd1103515245 + 32'd12345;
        return lcgState;
    endfunction

    // JCN condition from TEST, carry, zero and the opa mask
    function automatic logic ccExpect(input logic test, input logic carry, input logic zero,
                                      input logic [3:0] cond);
        logic hit;
        hit = (~test & cond[0]) | (carry & cond[1]) | (zero & cond[2]);
        return hit ^ cond[3];
    endfunction

    function automatic aluCtrlT aluOn(input oprE op, input fOpE sub, input aluSrcE src);
        aluCtrlT a;
        a = '{enable: 1'b1, op: op, subOp: sub, src: src};
        return a;
    endfunction

    // Row with idle expectations, random target and ALU result bits
    function automatic rowT newRow(input oprE o, input logic [3:0] a, input microCycleE c,
                                   input logic imm);
        rowT         r;
        logic [31:0] rnd;
        rnd = nextRand();
        r = '0;
        r.opr = o;
        r.opa = a;
        r.cycle = c;
        r.immFetch = imm;
        r.immAddr = rnd[27:16];
        r.carryIn = rnd[29];
        r.zeroIn = rnd[30];
        r.testIn = testLevel;
        r.expAlu = aluIdle;
        r.expReg.tempWe = (c == cycX1);
        r.expCarry = modelCarry;
        r.expZero = modelZero;
        return r;
    endfunction

    task automatic pushRow(input rowT r);
        rowT q;
        q = r;
        q.expCc = ccExpect(lastTest, q.expCarry, q.expZero, q.opa);   // Sync lags one row
        lastTest = q.testIn;
        rows.push_back(q);
    endtask

    task automatic execRow(input oprE o, input logic [3:0] a, input microCycleE c,
                           input aluCtrlT alu, input regCtrlT rg, input carryActE ca,
                           input logic zl);
        rowT r;
        r = newRow(o, a, c, 1'b0);
        r.expAlu = alu;
        r.expReg = rg;
        if (ca == carryKeep) begin
            r.carryIn = ~modelCarry;   // A stray load would flip the flag
        end
        if (!zl) begin
            r.zeroIn = ~modelZero;
        end
        case (ca)
            carryAlu:    modelCarry = r.carryIn;
            carryClear:  modelCarry = 1'b0;
            carrySet:    modelCarry = 1'b1;
            carryInvert: modelCarry = ~modelCarry;
            default: ;
        endcase
        if (zl) modelZero = r.zeroIn;
        r.expCarry = modelCarry;
        r.expZero = modelZero;
        pushRow(r);
    endtask

    task automatic accRow(input fOpE f, input regCtrlT rg, input carryActE ca, input logic zl);
        execRow(grpF, 4'(f), cycX3, aluOn(grpF, f, srcNone), rg, ca, zl);
    endtask

    task automatic firstWord(input oprE o, input logic [3:0] a);
        rowT r;
        r = newRow(o, a, cycX3, 1'b0);
        r.expNeed = 1'b1;
        r.expFin = (o == FIN);
        pushRow(r);
    endtask

    task automatic jcnCase(input logic test, input logic [3:0] cond);
        rowT r;
        testLevel = test;
        pushRow(newRow(NOP, 4'h0, cycA1, 1'b0));   // TEST held two clocks before the jump
        firstWord(JCN, cond);
        r = newRow(JCN, cond, cycX3, 1'b1);
        if (ccExpect(test, modelCarry, modelZero, cond)) begin
            r.expPc.pcLoad = 1'b1;
            r.expPc.pcLoadData = r.immAddr;
        end
        pushRow(r);
    endtask

    task automatic pairFetch(input oprE o, input logic [3:0] a);
        rowT r;
        firstWord(o, a);
        r = newRow(o, a, cycX3, 1'b1);
        r.expPair.pairWe = 1'b1;
        r.expPair.pairAddr = {a[3:1], 1'b0};
        r.expPair.pairDin = r.immAddr[7:0];
        pushRow(r);
    endtask

    task automatic iszCase(input logic zeroAtX2);
        rowT r;
        firstWord(ISZ, 4'h6);
        r = newRow(ISZ, 4'h6, cycX2, 1'b1);
        r.zeroIn = zeroAtX2;
        r.expAlu = aluOn(INC, CLB, srcReg);
        pushRow(r);
        r = newRow(ISZ, 4'h6, cycX3, 1'b1);
        r.expReg = regOnly;
        if (!zeroAtX2) begin   // Branch back while the register is nonzero
            r.expPc.pcLoad = 1'b1;
            r.expPc.pcLoadData = r.immAddr;
        end
        pushRow(r);
    endtask

    task automatic buildTable();
        rowT r;
        pushRow(newRow(NOP, 4'h0, cycA1, 1'b0));   // Idle frame parks src at srcNone
        execRow(ADD, 4'h2, cycX1, aluOn(ADD, CLB, srcReg), tempOnly, carryKeep, 1'b0);
        execRow(ADD, 4'h2, cycX3, aluOn(ADD, CLB, srcReg), accOnly, carryAlu, 1'b1);
        execRow(SUB, 4'h9, cycX3, aluOn(SUB, CLB, srcReg), accOnly, carryAlu, 1'b1);
        execRow(INC, 4'h5, cycX3, aluOn(INC, CLB, srcReg), regOnly, carryAlu, 1'b1);
        execRow(LD, 4'hC, cycX3, aluOn(LD, CLB, srcReg), accOnly, carryKeep, 1'b1);
        execRow(XCH, 4'h3, cycX1, aluOn(LD, CLB, srcReg), tempOnly, carryKeep, 1'b0);
        execRow(XCH, 4'h3, cycX3, aluOn(LD, CLB, srcReg), xchWb, carryKeep, 1'b1);
        execRow(LDM, 4'h7, cycX3, aluOn(LDM, CLB, srcImm), accOnly, carryKeep, 1'b1);
        // Carry walk 1, 0, 1, 0, 0
        accRow(STC, regIdle, carrySet, 1'b0);
        accRow(CMC, regIdle, carryInvert, 1'b0);
        accRow(CMC, regIdle, carryInvert, 1'b0);
        accRow(CLC, regIdle, carryClear, 1'b0);
        accRow(TCS, accOnly, carryClear, 1'b0);
        accRow(RAL, accOnly, carryAlu, 1'b0);
        accRow(CMA, accOnly, carryKeep, 1'b1);
        accRow(CLB, accOnly, carryClear, 1'b1);
        execRow(grpF, 4'hD, cycX3, aluIdle, regIdle, carryKeep, 1'b0);   // DCL is a no-op
        jcnCase(1'b0, 4'b0001);
        jcnCase(1'b1, 4'b0001);
        jcnCase(1'b1, 4'b1001);
        jcnCase(1'b1, 4'b0010);
        jcnCase(1'b1, 4'b0100);
        accRow(STC, regIdle, carrySet, 1'b0);
        jcnCase(1'b0, 4'b0010);
        jcnCase(1'b0, 4'b1110);
        // ---------------------------------------------------------------------------
        // Two-word instructions, stack and pairs
        // ---------------------------------------------------------------------------
        firstWord(JUN, 4'h4);
        r = newRow(JUN, 4'h4, cycX3, 1'b1);
        r.expPc.pcLoad = 1'b1;
        r.expPc.pcLoadData = r.immAddr;
        pushRow(r);
        firstWord(JMS, 4'hA);
        r = newRow(JMS, 4'hA, cycX3, 1'b1);
        r.expPc.pcLoad = 1'b1;
        r.expPc.pcLoadData = r.immAddr;
        r.expPc.stackPush = 1'b1;
        pushRow(r);
        r = newRow(BBL, 4'h3, cycX3, 1'b0);
        r.expAlu = aluOn(BBL, CLB, srcImm);
        r.expReg = accOnly;
        r.expPc.stackPop = 1'b1;
        pushRow(r);
        pairFetch(FIN, 4'h6);
        pairFetch(FIM, 4'h4);
        r = newRow(FIM, 4'hB, cycX1, 1'b0);   // SRC
        r.expPair.pairAddr = 4'hA;
        pushRow(r);
        r = newRow(FIN, 4'h7, cycX1, 1'b0);   // JIN
        r.expPair.pairAddr = 4'h6;
        pushRow(r);
        r = newRow(FIN, 4'h7, cycX3, 1'b0);
        r.expPc.pcLoadUsePair = 1'b1;
        pushRow(r);
        iszCase(1'b0);
        iszCase(1'b1);
    endtask

    // ---------------------------------------------------------------------------
    // Compare tasks
    // ---------------------------------------------------------------------------

    task automatic reportMismatch(input string field, input logic [31:0] got,
                                  input logic [31:0] exp);
        $display("ERR %0t ns: row %0d %s got %0h expected %0h", $time, curRow, field, got, exp);
        $display("TB FAILED");
        $fatal(1, "Stopping at the first mismatch");
    endtask

    task automatic checkAluCtrl(input aluCtrlT got, input aluCtrlT exp);
        if (got !== exp) reportMismatch("aluCtrl", 32'(got), 32'(exp));
    endtask

    task automatic checkRegCtrl(input regCtrlT got, input regCtrlT exp);
        if (got !== exp) reportMismatch("regCtrl", 32'(got), 32'(exp));
    endtask

    task automatic checkPcCtrl(input pcCtrlT got, input pcCtrlT exp);
        if (got !== exp) reportMismatch("pcCtrl", 32'(got), 32'(exp));
    endtask

    task automatic checkPairCtrl(input pairCtrlT got, input pairCtrlT exp);
        if (got !== exp) reportMismatch("pairCtrl", 32'(got), 32'(exp));
    endtask

    task automatic checkFlags(input logic carryGot, input logic zeroGot, input logic ccGot,
                              input rowT r);
        if (carryGot !== r.expCarry) reportMismatch("carryFlag", 32'(carryGot), 32'(r.expCarry));
        if (zeroGot !== r.expZero) reportMismatch("zeroFlag", 32'(zeroGot), 32'(r.expZero));
        if (ccGot !== r.expCc) reportMismatch("ccOut", 32'(ccGot), 32'(r.expCc));
    endtask

    task automatic checkStrobes(input logic needGot, input logic finGot, input rowT r);
        if (needGot !== r.expNeed) reportMismatch("needImm", 32'(needGot), 32'(r.expNeed));
        if (finGot !== r.expFin) reportMismatch("finImm", 32'(finGot), 32'(r.expFin));
    endtask

    task automatic checkRow(input rowT r);
        checkAluCtrl(aluCtrl, r.expAlu);
        checkRegCtrl(regCtrl, r.expReg);
        checkPcCtrl(pcCtrl, r.expPc);
        checkPairCtrl(pairCtrl, r.expPair);
        checkFlags(carryFlag, zeroFlag, ccOut, r);
        checkStrobes(needImm, finImm, r);
    endtask

    task automatic applyRow(input rowT r);
        opr = r.opr;
        opa = r.opa;
        cycle = r.cycle;
        immFetchActive = r.immFetch;
        immAddr = r.immAddr;
        carryFromAlu = r.carryIn;
        zeroFromAlu = r.zeroIn;
        testFlag = r.testIn;
    endtask

    initial begin
        int waitCount;
        opr = NOP;
        opa = '0;
        cycle = cycA1;
        carryFromAlu = 1'b0;
        zeroFromAlu = 1'b0;
        testFlag = 1'b0;
        immFetchActive = 1'b0;
        immAddr = '0;
        lcgState = 32'd86;
        modelCarry = 1'b0;
        modelZero = 1'b0;
        testLevel = 1'b0;
        lastTest = 1'b0;
        buildTable();

        @(posedge clk);
        #1;
        curRow = -1;
        checkRow('0);   // Everything cleared while in reset

        waitCount = 0;
        while (rstN !== 1'b1 && waitCount < 10) begin
            @(posedge clk);
            waitCount++;
        end
        if (rstN !== 1'b1) begin
            $display("Timeout: reset was never released");
            $display("TB FAILED");
            $fatal(1, "Reset wait expired");
        end
        #1;

        for (int i = 0; i < rows.size(); i++) begin
            curRow = i;
            applyRow(rows[i]);
            @(posedge clk);
            #1;
            checkRow(rows[i]);
        end

        $display("TB PASSED");
        $finish;
    end

endmodule

`default_nettype wire
